/* design/wb_pkg.sv */
`default_nettype none

package wb_pkg;

    // slot count is fixed by the execute stage result format
    localparam int NUM_SLOTS = 4;

    // micro-op control word bit positions
    localparam int P_OP_HALT  = 9;
    localparam int P_OP_FAR_A = 36; // far jmp
    localparam int P_OP_FAR_B = 35; // far call
    localparam int P_OP_FAR_C = 32; // far ret / iret

    // slot result value
    typedef logic [63:0] data_t;

    // memory address, or register index in the low bits
    typedef logic [31:0] addr_t;

    // instruction pointer / fetch address
    typedef logic [31:0] eip_t;

    // gpr or segment index
    typedef logic [2:0] reg_idx_t;

    // 0 byte, 1 word, 2 dword, 3 qword
    typedef logic [1:0] opsize_t;

    // one bit per result slot
    typedef logic [NUM_SLOTS-1:0] slot_mask_t;

    // exception type, msb marks external interrupt
    typedef logic [3:0] ie_type_t;

    // micro-op control word
    typedef logic [36:0] p_op_t;

endpackage

`default_nettype wire

/* design/wb_dest_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module wb_dest_decode (
    input  wire wb_pkg::data_t      slot_data [wb_pkg::NUM_SLOTS],
    input  wire wb_pkg::addr_t      slot_dest [wb_pkg::NUM_SLOTS],
    input  wire wb_pkg::slot_mask_t is_reg,
    input  wire wb_pkg::slot_mask_t is_seg,
    input  wire wb_pkg::slot_mask_t is_mem,
    input  wire wb_pkg::slot_mask_t slot_wb,
    input  wire wb_pkg::opsize_t    op_size,
    input  wire [3:0]               size_ovr,
    input  wire                     far_xfer,

    output wb_pkg::slot_mask_t      reg_mask,
    output wb_pkg::slot_mask_t      seg_mask,
    output wb_pkg::slot_mask_t      mem_mask,
    output logic [11:0]             reg_addr,
    output logic [11:0]             seg_addr,
    output logic                    store_any,
    output wb_pkg::data_t           store_data,
    output wb_pkg::addr_t           store_addr,
    output wb_pkg::opsize_t         mem_size_raw
);

    wb_pkg::reg_idx_t dest_idx [wb_pkg::NUM_SLOTS];

    // kind flag only counts when the slot actually writes back
    assign reg_mask = is_reg & slot_wb;
    assign seg_mask = is_seg & slot_wb;
    assign mem_mask = is_mem & slot_wb;

    assign store_any = |mem_mask;

    always_comb begin
        for (int i = 0; i < wb_pkg::NUM_SLOTS; i++) begin
            dest_idx[i] = slot_dest[i][2:0];
        end
    end

    // same index packing feeds both register files, slot 0 in the low bits
    always_comb begin
        reg_addr = '0;
        seg_addr = '0;
        for (int i = 0; i < wb_pkg::NUM_SLOTS; i++) begin
            reg_addr[3*i +: 3] = dest_idx[i];
            seg_addr[3*i +: 3] = dest_idx[i];
        end
    end

    // store slot select, walk downward so the lowest set slot wins
    always_comb begin
        store_data = '0;
        store_addr = '0;
        for (int i = wb_pkg::NUM_SLOTS - 1; i >= 0; i--) begin
            if (mem_mask[i]) begin
                store_data = slot_data[i];
                store_addr = slot_dest[i];
            end
        end
    end

    // size priority: lowest override bit, then far transfer, then op size
    always_comb begin
        if (far_xfer) begin
            mem_size_raw = 2'd3; // far pointer store is always qword
        end else begin
            mem_size_raw = op_size;
        end
        for (int k = 3; k >= 0; k--) begin
            if (size_ovr[k]) begin
                mem_size_raw = wb_pkg::opsize_t'(k);
            end
        end
    end

    // execute never hands over more than one store per instruction
    a_one_store: assert property (@(mem_mask) $onehot0(mem_mask))
        else $error("wb_dest_decode: more than one mem slot set (%b)", mem_mask);

endmodule

`default_nettype wire

/* design/wb_branch_resolve.sv */
`timescale 1ns/1ns
`default_nettype none

module wb_branch_resolve (
    input  wire wb_pkg::p_op_t  p_op,
    input  wire wb_pkg::eip_t   eip_in,
    input  wire wb_pkg::eip_t   br_fip,
    input  wire wb_pkg::eip_t   br_fip_p1,
    input  wire wb_pkg::data_t  slot0_data,
    input  wire                 br_valid,
    input  wire                 br_taken,
    input  wire                 br_correct,

    output logic                far_xfer,
    output wb_pkg::eip_t        new_eip,
    output wb_pkg::eip_t        new_fip_e,
    output wb_pkg::eip_t        new_fip_o,
    output logic                mispredict
);

    wb_pkg::eip_t taken_eip;
    wb_pkg::eip_t fip_line;
    wb_pkg::eip_t fip_p1_line;

    // far jmp/call/ret load eip and cs together
    assign far_xfer = p_op[wb_pkg::P_OP_FAR_A]
                    | p_op[wb_pkg::P_OP_FAR_B]
                    | p_op[wb_pkg::P_OP_FAR_C];

    // far target offset sits in the low half of slot 0
    assign taken_eip = far_xfer ? slot0_data[31:0] : br_fip;

    always_comb begin
        if (br_taken) begin
            new_eip = taken_eip;
        end else begin
            new_eip = eip_in;
        end
    end

    // 16 byte fetch lines
    assign fip_line    = {br_fip[31:4], 4'h0};
    assign fip_p1_line = {br_fip_p1[31:4], 4'h0};

    // bit 4 tells which bank the target line falls in
    always_comb begin
        if (br_fip[4]) begin
            new_fip_e = fip_p1_line;
            new_fip_o = fip_line;
        end else begin
            new_fip_e = fip_line;
            new_fip_o = fip_p1_line;
        end
    end

    assign mispredict = br_valid & ~br_correct;

endmodule

`default_nettype wire

/* design/wb_commit.sv */
`timescale 1ns/1ns
`default_nettype none

module wb_commit (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     in_valid,
    input  wire wb_pkg::slot_mask_t reg_mask,
    input  wire wb_pkg::slot_mask_t seg_mask,
    input  wire                     store_any,
    input  wire                     mem_ready,
    input  wire                     mispredict,
    input  wire                     halt_op,
    input  wire                     ie_in,
    input  wire wb_pkg::ie_type_t   ie_type_in,
    input  wire                     interrupt_in,

    output logic                    in_ready,
    output logic                    mem_valid,
    output wb_pkg::slot_mask_t      reg_ld,
    output wb_pkg::slot_mask_t      seg_ld,
    output logic                    halt,
    output logic                    ie_val,
    output wb_pkg::ie_type_t        ie_type,
    output logic                    is_resteer
);

    logic fire;
    logic resteer_nxt;

    // only a store beat can be held back by the queue
    assign in_ready  = ~store_any | mem_ready;
    assign mem_valid = in_valid & store_any; // no dependency on mem_ready

    assign fire = in_valid & in_ready;

    // nothing architectural happens on a stalled beat
    assign reg_ld = reg_mask & {wb_pkg::NUM_SLOTS{fire}};
    assign seg_ld = seg_mask & {wb_pkg::NUM_SLOTS{fire}};
    assign halt   = fire & halt_op;

    assign ie_val  = fire & (ie_in | interrupt_in);
    assign ie_type = {interrupt_in, ie_type_in[2:0]}; // msb flags the interrupt

    assign resteer_nxt = fire & mispredict;

    always_ff @(posedge clk) begin
        if (rst) begin
            is_resteer <= 1'b0;
        end else begin
            is_resteer <= resteer_nxt; // one cycle pulse to fetch
        end
    end

    // a store the queue can't take stays offered until it is taken
    a_store_stall: assert property (
        @(posedge clk) disable iff (rst)
        mem_valid && !mem_ready |=> mem_valid
    ) else $error("wb_commit: store beat withdrawn before the store queue took it");

endmodule

`default_nettype wire

/* design/writeback_top.sv */
`timescale 1ns/1ns
`default_nettype none

module writeback_top (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   in_valid,

    input  wire wb_pkg::data_t    slot1_data,
    input  wire wb_pkg::data_t    slot2_data,
    input  wire wb_pkg::data_t    slot3_data,
    input  wire wb_pkg::data_t    slot4_data,
    input  wire wb_pkg::addr_t    slot1_dest,
    input  wire wb_pkg::addr_t    slot2_dest,
    input  wire wb_pkg::addr_t    slot3_dest,
    input  wire wb_pkg::addr_t    slot4_dest,
    input  wire                   slot1_is_reg,
    input  wire                   slot2_is_reg,
    input  wire                   slot3_is_reg,
    input  wire                   slot4_is_reg,
    input  wire                   slot1_is_seg,
    input  wire                   slot2_is_seg,
    input  wire                   slot3_is_seg,
    input  wire                   slot4_is_seg,
    input  wire                   slot1_is_mem,
    input  wire                   slot2_is_mem,
    input  wire                   slot3_is_mem,
    input  wire                   slot4_is_mem,
    input  wire                   slot1_wb,
    input  wire                   slot2_wb,
    input  wire                   slot3_wb,
    input  wire                   slot4_wb,

    input  wire wb_pkg::opsize_t  op_size,
    input  wire [3:0]             size_ovr,
    input  wire wb_pkg::p_op_t    p_op,
    input  wire wb_pkg::eip_t     eip_in,
    input  wire wb_pkg::eip_t     br_fip,
    input  wire wb_pkg::eip_t     br_fip_p1,
    input  wire                   br_valid,
    input  wire                   br_taken,
    input  wire                   br_correct,
    input  wire                   ie_in,
    input  wire wb_pkg::ie_type_t ie_type_in,
    input  wire                   interrupt_in,
    input  wire                   mem_ready,

    output logic                  in_ready,
    output wb_pkg::data_t         res1,
    output wb_pkg::data_t         res2,
    output wb_pkg::data_t         res3,
    output wb_pkg::data_t         res4,
    output logic [11:0]           reg_addr,
    output wb_pkg::slot_mask_t    reg_ld,
    output logic [11:0]           seg_addr,
    output wb_pkg::slot_mask_t    seg_ld,
    output logic                  mem_valid,
    output wb_pkg::addr_t         mem_addr,
    output wb_pkg::data_t         mem_data,
    output wb_pkg::opsize_t       mem_size,
    output wb_pkg::eip_t          new_eip,
    output wb_pkg::eip_t          new_fip_e,
    output wb_pkg::eip_t          new_fip_o,
    output logic                  is_resteer,
    output logic                  halt,
    output logic                  ie_val,
    output wb_pkg::ie_type_t      ie_type
);

    wb_pkg::data_t      slot_data [wb_pkg::NUM_SLOTS];
    wb_pkg::addr_t      slot_dest [wb_pkg::NUM_SLOTS];
    wb_pkg::slot_mask_t reg_mask;
    wb_pkg::slot_mask_t seg_mask;
    logic               store_any;
    logic               far_xfer;
    logic               mispredict;

    // slot 1 is index 0 throughout
    assign slot_data = '{slot1_data, slot2_data, slot3_data, slot4_data};
    assign slot_dest = '{slot1_dest, slot2_dest, slot3_dest, slot4_dest};

    wb_dest_decode u_dest (
        .slot_data    (slot_data),
        .slot_dest    (slot_dest),
        .is_reg       ({slot4_is_reg, slot3_is_reg, slot2_is_reg, slot1_is_reg}),
        .is_seg       ({slot4_is_seg, slot3_is_seg, slot2_is_seg, slot1_is_seg}),
        .is_mem       ({slot4_is_mem, slot3_is_mem, slot2_is_mem, slot1_is_mem}),
        .slot_wb      ({slot4_wb, slot3_wb, slot2_wb, slot1_wb}),
        .op_size      (op_size),
        .size_ovr     (size_ovr),
        .far_xfer     (far_xfer),
        .reg_mask     (reg_mask),
        .seg_mask     (seg_mask),
        .mem_mask     (),
        .reg_addr     (reg_addr),
        .seg_addr     (seg_addr),
        .store_any    (store_any),
        .store_data   (mem_data),
        .store_addr   (mem_addr),
        .mem_size_raw (mem_size)
    );

    wb_branch_resolve u_branch (
        .p_op       (p_op),
        .eip_in     (eip_in),
        .br_fip     (br_fip),
        .br_fip_p1  (br_fip_p1),
        .slot0_data (slot1_data),
        .br_valid   (br_valid),
        .br_taken   (br_taken),
        .br_correct (br_correct),
        .far_xfer   (far_xfer),
        .new_eip    (new_eip),
        .new_fip_e  (new_fip_e),
        .new_fip_o  (new_fip_o),
        .mispredict (mispredict)
    );

    wb_commit u_commit (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .reg_mask     (reg_mask),
        .seg_mask     (seg_mask),
        .store_any    (store_any),
        .mem_ready    (mem_ready),
        .mispredict   (mispredict),
        .halt_op      (p_op[wb_pkg::P_OP_HALT]),
        .ie_in        (ie_in),
        .ie_type_in   (ie_type_in),
        .interrupt_in (interrupt_in),
        .in_ready     (in_ready),
        .mem_valid    (mem_valid),
        .reg_ld       (reg_ld),
        .seg_ld       (seg_ld),
        .halt         (halt),
        .ie_val       (ie_val),
        .ie_type      (ie_type),
        .is_resteer   (is_resteer)
    );

    // far transfer puts the cs selector on result 1 for the segment write
    assign res1 = far_xfer ? {48'h0, slot1_data[47:32]} : slot1_data;
    assign res2 = slot2_data;
    assign res3 = slot3_data;
    assign res4 = slot4_data;

    // a held store keeps its address, data and size
    a_store_stable: assert property (@(posedge clk) disable iff (rst)
        mem_valid && !mem_ready |=>
            $stable(mem_addr) && $stable(mem_data) && $stable(mem_size))
        else $error("writeback_top: store fields changed while waiting on the queue");

endmodule

`default_nettype wire

/* dv/wb_model.svh */
// one-hot of the lowest slot that is both a mem slot and written back
function automatic logic [3:0] first_store_slot(input logic [3:0] is_mem, input logic [3:0] wb);
    logic [3:0] m;
    m = is_mem & wb;
    return m & (~m + 4'd1);
endfunction

// override bit k means size k, lowest bit first
function automatic wb_pkg::opsize_t resolved_mem_size(input logic [3:0] ovr, input logic far,
                                                      input wb_pkg::opsize_t op_size);
    if (ovr[0]) return 2'd0;
    if (ovr[1]) return 2'd1;
    if (ovr[2]) return 2'd2;
    if (ovr[3]) return 2'd3;
    if (far) return 2'd3; // far pointer
    return op_size;
endfunction

function automatic logic is_far_transfer(input wb_pkg::p_op_t p_op);
    return p_op[wb_pkg::P_OP_FAR_A] || p_op[wb_pkg::P_OP_FAR_B] || p_op[wb_pkg::P_OP_FAR_C];
endfunction

function automatic wb_pkg::eip_t next_eip(input logic taken, input logic far,
                                          input wb_pkg::data_t slot1, input wb_pkg::eip_t fip,
                                          input wb_pkg::eip_t eip);
    if (!taken) return eip;
    return far ? slot1[31:0] : fip;
endfunction

// 16 byte lines
function automatic wb_pkg::eip_t fetch_line(input wb_pkg::eip_t a);
    return a & 32'hffff_fff0;
endfunction

function automatic wb_pkg::eip_t even_fetch_line(input wb_pkg::eip_t fip,
                                                 input wb_pkg::eip_t fip_p1);
    return fip[4] ? fetch_line(fip_p1) : fetch_line(fip);
endfunction

function automatic wb_pkg::eip_t odd_fetch_line(input wb_pkg::eip_t fip,
                                                input wb_pkg::eip_t fip_p1);
    return fip[4] ? fetch_line(fip) : fetch_line(fip_p1);
endfunction

// cs selector lives in bits 47:32 of slot 1
function automatic wb_pkg::data_t cs_result(input logic far, input wb_pkg::data_t d);
    return far ? 64'(d[47:32]) : d;
endfunction

function automatic logic [11:0] packed_indices(input wb_pkg::addr_t d0, input wb_pkg::addr_t d1,
                                               input wb_pkg::addr_t d2, input wb_pkg::addr_t d3);
    return {d3[2:0], d2[2:0], d1[2:0], d0[2:0]};
endfunction

function automatic wb_pkg::ie_type_t merged_ie_type(input logic intr, input wb_pkg::ie_type_t t);
    return {intr, t[2:0]};
endfunction

/* dv/tb_writeback.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_writeback;

    localparam int NUM_CYCLES  = 3000;
    localparam int STALL_LIMIT = 64; // cycles a store beat may wait on the queue

    logic               clk = 1'b0;
    logic               rst;
    logic               in_valid;
    wb_pkg::data_t      slot1_data;
    wb_pkg::data_t      slot2_data;
    wb_pkg::data_t      slot3_data;
    wb_pkg::data_t      slot4_data;
    wb_pkg::addr_t      slot1_dest;
    wb_pkg::addr_t      slot2_dest;
    wb_pkg::addr_t      slot3_dest;
    wb_pkg::addr_t      slot4_dest;
    logic               slot1_is_reg;
    logic               slot2_is_reg;
    logic               slot3_is_reg;
    logic               slot4_is_reg;
    logic               slot1_is_seg;
    logic               slot2_is_seg;
    logic               slot3_is_seg;
    logic               slot4_is_seg;
    logic               slot1_is_mem;
    logic               slot2_is_mem;
    logic               slot3_is_mem;
    logic               slot4_is_mem;
    logic               slot1_wb;
    logic               slot2_wb;
    logic               slot3_wb;
    logic               slot4_wb;
    wb_pkg::opsize_t    op_size;
    logic [3:0]         size_ovr;
    wb_pkg::p_op_t      p_op;
    wb_pkg::eip_t       eip_in;
    wb_pkg::eip_t       br_fip;
    wb_pkg::eip_t       br_fip_p1;
    logic               br_valid;
    logic               br_taken;
    logic               br_correct;
    logic               ie_in;
    wb_pkg::ie_type_t   ie_type_in;
    logic               interrupt_in;
    logic               mem_ready;

    logic               in_ready;
    wb_pkg::data_t      res1;
    wb_pkg::data_t      res2;
    wb_pkg::data_t      res3;
    wb_pkg::data_t      res4;
    logic [11:0]        reg_addr;
    wb_pkg::slot_mask_t reg_ld;
    logic [11:0]        seg_addr;
    wb_pkg::slot_mask_t seg_ld;
    logic               mem_valid;
    wb_pkg::addr_t      mem_addr;
    wb_pkg::data_t      mem_data;
    wb_pkg::opsize_t    mem_size;
    wb_pkg::eip_t       new_eip;
    wb_pkg::eip_t       new_fip_e;
    wb_pkg::eip_t       new_fip_o;
    logic               is_resteer;
    logic               halt;
    logic               ie_val;
    wb_pkg::ie_type_t   ie_type;

    logic [31:0]        rng_state;
    logic               resteer_exp; // model copy of the resteer flop
    logic               held;
    int                 stall_cycles;

    `include "wb_model.svh"

    writeback_top u_writeback_top (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "output check failed");
        end
    endtask

    task automatic drive_beat();
        logic [31:0] r;
        logic [3:0]  mem_sel;
        slot1_data = {next_rand(), next_rand()};
        slot2_data = {next_rand(), next_rand()};
        slot3_data = {next_rand(), next_rand()};
        slot4_data = {next_rand(), next_rand()};
        slot1_dest = next_rand();
        slot2_dest = next_rand();
        slot3_dest = next_rand();
        slot4_dest = next_rand();
        r = next_rand();
        in_valid = r[1:0] != 2'b00;
        {slot4_is_reg, slot3_is_reg, slot2_is_reg, slot1_is_reg} = r[5:2];
        {slot4_is_seg, slot3_is_seg, slot2_is_seg, slot1_is_seg} = r[9:6] & r[13:10];
        {slot4_wb, slot3_wb, slot2_wb, slot1_wb} = r[17:14] | r[21:18];
        mem_sel = r[24] ? 4'b0001 << r[23:22] : 4'b0000; // at most one mem slot
        {slot4_is_mem, slot3_is_mem, slot2_is_mem, slot1_is_mem} = mem_sel;
        op_size = r[26:25];
        size_ovr = r[27] ? r[31:28] : 4'h0;
        r = next_rand();
        br_valid = r[0];
        br_taken = r[1];
        br_correct = r[2] | r[3];
        ie_in = r[6:4] == 3'd0;
        interrupt_in = r[9:7] == 3'd0;
        ie_type_in = r[13:10];
        p_op = {r[18:14], next_rand()};
        // far transfers in about a quarter of the beats
        if (r[20:19] != 2'b00) begin
            p_op[wb_pkg::P_OP_FAR_A] = 1'b0;
            p_op[wb_pkg::P_OP_FAR_B] = 1'b0;
            p_op[wb_pkg::P_OP_FAR_C] = 1'b0;
        end
        eip_in = next_rand();
        br_fip = next_rand();
        br_fip_p1 = next_rand();
    endtask

    task automatic check_outputs();
        logic [3:0]    mem_v;
        logic [3:0]    wb_v;
        logic [3:0]    sel;
        logic          ready_exp;
        logic          fire_exp;
        logic          far_exp;
        wb_pkg::data_t st_data;
        wb_pkg::addr_t st_addr;
        mem_v = {slot4_is_mem, slot3_is_mem, slot2_is_mem, slot1_is_mem};
        wb_v = {slot4_wb, slot3_wb, slot2_wb, slot1_wb};
        sel = first_store_slot(mem_v, wb_v);
        ready_exp = sel == 4'h0 || mem_ready;
        fire_exp = in_valid && ready_exp;
        far_exp = is_far_transfer(p_op);

        check_val("in_ready", 64'(in_ready), 64'(ready_exp));
        check_val("reg_ld", 64'(reg_ld), 64'(fire_exp ?
            {slot4_is_reg, slot3_is_reg, slot2_is_reg, slot1_is_reg} & wb_v : 4'h0));
        check_val("seg_ld", 64'(seg_ld), 64'(fire_exp ?
            {slot4_is_seg, slot3_is_seg, slot2_is_seg, slot1_is_seg} & wb_v : 4'h0));
        check_val("reg_addr", 64'(reg_addr),
            64'(packed_indices(slot1_dest, slot2_dest, slot3_dest, slot4_dest)));
        check_val("seg_addr", 64'(seg_addr),
            64'(packed_indices(slot1_dest, slot2_dest, slot3_dest, slot4_dest)));

        // store path
        check_val("mem_valid", 64'(mem_valid), 64'(in_valid && sel != 4'h0));
        check_val("mem_size", 64'(mem_size),
            64'(resolved_mem_size(size_ovr, far_exp, op_size)));
        if (sel != 4'h0) begin
            st_data = ({64{sel[0]}} & slot1_data) | ({64{sel[1]}} & slot2_data)
                    | ({64{sel[2]}} & slot3_data) | ({64{sel[3]}} & slot4_data);
            st_addr = ({32{sel[0]}} & slot1_dest) | ({32{sel[1]}} & slot2_dest)
                    | ({32{sel[2]}} & slot3_dest) | ({32{sel[3]}} & slot4_dest);
            check_val("mem_data", mem_data, st_data);
            check_val("mem_addr", 64'(mem_addr), 64'(st_addr));
        end

        check_val("new_eip", 64'(new_eip),
            64'(next_eip(br_taken, far_exp, slot1_data, br_fip, eip_in)));
        check_val("new_fip_e", 64'(new_fip_e), 64'(even_fetch_line(br_fip, br_fip_p1)));
        check_val("new_fip_o", 64'(new_fip_o), 64'(odd_fetch_line(br_fip, br_fip_p1)));
        check_val("res1", res1, cs_result(far_exp, slot1_data));
        check_val("res2", res2, slot2_data);
        check_val("res3", res3, slot3_data);
        check_val("res4", res4, slot4_data);

        check_val("halt", 64'(halt), 64'(fire_exp && p_op[wb_pkg::P_OP_HALT]));
        check_val("ie_val", 64'(ie_val), 64'(fire_exp && (ie_in || interrupt_in)));
        check_val("ie_type", 64'(ie_type), 64'(merged_ie_type(interrupt_in, ie_type_in)));

        resteer_exp = fire_exp && br_valid && !br_correct;
        held = in_valid && !ready_exp; // beat retried whole next cycle
        stall_cycles = held ? stall_cycles + 1 : 0;
        if (stall_cycles > STALL_LIMIT) begin
            $display("store beat still not accepted after %0d cycles", STALL_LIMIT);
            $display("TESTS FAILED");
            $fatal(1, "store queue stall timeout");
        end
    endtask

    initial begin
        rng_state = 32'h0b80_e444;
        rst = 1'b1;
        resteer_exp = 1'b0;
        held = 1'b0;
        stall_cycles = 0;
        mem_ready = 1'b0;
        drive_beat();
        in_valid = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int cycle = 0; cycle < NUM_CYCLES; cycle++) begin
            // flop has settled since the last rising edge
            check_val("is_resteer", 64'(is_resteer), 64'(resteer_exp));
            if (!held) begin
                drive_beat();
            end
            mem_ready = next_rand() % 32'd10 < 32'd6;
            @(posedge clk);
            check_outputs();
            @(negedge clk);
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+dv
design/wb_pkg.sv
design/wb_dest_decode.sv
design/wb_branch_resolve.sv
design/wb_commit.sv
design/writeback_top.sv
dv/tb_writeback.sv

/* run.sh */
#!/bin/sh
# build and run the writeback testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f build.f --top-module tb_writeback
out=$(./obj_dir/Vtb_writeback 2>&1) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "TESTS PASSED"
